// File: src/ctrl_pkg.sv
// widths, event vectors, opcode classes, jump tests, opcode union, decode and alu structs
`default_nettype none

package ctrl_pkg;

	localparam int THREADS   = 8;                 // barrel threads
	localparam int THRD_W    = 3;                 // thread id width
	localparam int ADDR_W    = 16;                // pc width
	localparam int DATA_W    = 32;                // alu data width
	localparam int B_LO_W    = DATA_W / 2;        // low half of operand b
	localparam int IM_DATA_W = 8;                 // immediate data
	localparam int IM_ADDR_W = 6;                 // signed jump offset
	localparam int OP_CODE_W = 16;                // opcode word
	localparam int OP_CLS_W  = 4;                 // class field
	localparam int TST_W     = 2;                 // jump test field

	// vector = base | thread id
	localparam logic [ADDR_W-1:0] CLR_BASE  = 16'h0000;
	localparam logic [ADDR_W-1:0] INTR_BASE = 16'h0008;

	localparam logic [OP_CLS_W-1:0] OP_NOP = 4'd0;
	localparam logic [OP_CLS_W-1:0] OP_LIT = 4'd1;  // load immediate
	localparam logic [OP_CLS_W-1:0] OP_ADD = 4'd2;
	localparam logic [OP_CLS_W-1:0] OP_SUB = 4'd3;
	localparam logic [OP_CLS_W-1:0] OP_JMP = 4'd4;  // relative, conditional
	localparam logic [OP_CLS_W-1:0] OP_GTO = 4'd5;  // pc = b_lo

	localparam logic [TST_W-1:0] TST_ALWAYS = 2'd0;
	localparam logic [TST_W-1:0] TST_NEZ    = 2'd1;  // a != 0
	localparam logic [TST_W-1:0] TST_LTZ    = 2'd2;  // a < 0
	localparam logic [TST_W-1:0] TST_GEZ    = 2'd3;  // a >= 0

	typedef struct packed {
		logic [OP_CLS_W-1:0]                     op_cls;
		logic [OP_CODE_W-OP_CLS_W-IM_DATA_W-1:0] rsvd;     // zero
		logic [IM_DATA_W-1:0]                    im_data;
	} lit_fmt_s;

	typedef struct packed {
		logic [OP_CLS_W-1:0]                           op_cls;
		logic [TST_W-1:0]                              tst;
		logic [OP_CODE_W-OP_CLS_W-TST_W-IM_ADDR_W-1:0] rsvd;  // zero
		logic [IM_ADDR_W-1:0]                          im_addr;
	} jmp_fmt_s;

	// one opcode word, two readings
	typedef union packed {
		lit_fmt_s lit_fmt;
		jmp_fmt_s jmp_fmt;
	} op_word_u;

	typedef enum logic [2:0] {
		PC_INC  = 3'd0,
		PC_JMP  = 3'd1,
		PC_GTO  = 3'd2,
		PC_CLR  = 3'd3,
		PC_INTR = 3'd4
	} pc_sel_e;

	typedef struct packed {
		pc_sel_e               pc_sel;   // next pc source
		logic [TST_W-1:0]      tst;
		logic [IM_ADDR_W-1:0]  im_addr;
		logic [THRD_W-1:0]     thrd;     // owner of this word
	} dec_s;

	typedef struct packed {
		logic                  valid;    // legal opcode issued
		logic                  lit;
		logic                  add;
		logic                  sub;
		logic [IM_DATA_W-1:0]  im_data;
	} alu_ctrl_s;

endpackage

`default_nettype wire

// File: src/thread_ring.sv
// thread counter with stage 0 and stage 1 thread ids
`timescale 1ns/1ns
`default_nettype none

module thread_ring import ctrl_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	output logic [THRD_W-1:0] thrd_0_o,  // thread at fetch
	output logic [THRD_W-1:0] thrd_1_o   // thread at decode
);

	logic [THRD_W-1:0] thrd_0, thrd_1;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			thrd_0 <= '0;
			thrd_1 <= THRD_W'(THREADS - 1);  // one behind
		end else begin
			thrd_0 <= (thrd_0 == THRD_W'(THREADS - 1)) ? '0 : thrd_0 + 1'b1;  // wrap
			thrd_1 <= thrd_0;  // registered copy
		end
	end

	assign thrd_0_o = thrd_0;
	assign thrd_1_o = thrd_1;

endmodule

`default_nettype wire

// File: src/event_ctrl.sv
// per-thread event latch with rising edge detect, enable, held ack and service strobe
`timescale 1ns/1ns
`default_nettype none

module event_ctrl import ctrl_pkg::*; #(
	parameter logic [THREADS-1:0] RESET_VAL = '0  // pending bits after reset
) (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic [THRD_W-1:0]  thrd_i,   // thread at fetch
	input  logic [THREADS-1:0] en_i,     // per-thread enable
	input  logic [THREADS-1:0] req_i,    // level requests
	output logic [THREADS-1:0] ack_o,    // high until serviced
	output logic               event_o   // service strobe
);

	logic [THREADS-1:0] req_q;   // previous requests
	logic [THREADS-1:0] pend;    // latched, not yet serviced
	logic [THREADS-1:0] rise;
	logic [THREADS-1:0] svc;     // one-hot service of current thread

	assign rise = req_i & ~req_q;  // low to high only
	assign svc  = pend & (THREADS'(1) << thrd_i);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			req_q <= '0;
			pend  <= RESET_VAL;
		end else begin
			req_q <= req_i;
			// a fresh edge survives the service of an older one
			pend  <= (pend & ~svc) | (rise & en_i);
		end
	end

	assign ack_o   = pend;  // ack is the pending bit
	assign event_o = |svc;  // thread turn meets pending bit

endmodule

`default_nettype wire

// File: src/op_decode.sv
// registered opcode decoder with event priority and illegal class detection
`timescale 1ns/1ns
`default_nettype none

module op_decode import ctrl_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [THRD_W-1:0] thrd_i,        // stage 0 thread
	input  logic              clr_i,         // clear strobe
	input  logic              intr_i,        // interrupt strobe
	input  op_word_u          op_code_i,     // fetched word
	output dec_s              dec_o,         // to pc ring, stage 1
	output alu_ctrl_s         alu_ctrl_o,    // stage 1
	output logic              op_code_er_o   // illegal class, one cycle
);

	logic [OP_CLS_W-1:0] op_cls;
	logic                evt;        // any event this turn
	logic                legal;
	logic                issue;      // opcode actually executes
	dec_s                dec_nxt;
	alu_ctrl_s           alu_nxt;

	assign op_cls = op_code_i.lit_fmt.op_cls;
	assign evt    = clr_i | intr_i;
	assign issue  = legal & ~evt;

	always_comb begin
		legal          = 1'b1;
		dec_nxt.pc_sel = PC_INC;
		case (op_cls)
			OP_NOP, OP_LIT, OP_ADD, OP_SUB: dec_nxt.pc_sel = PC_INC;
			OP_JMP:                         dec_nxt.pc_sel = PC_JMP;
			OP_GTO:                         dec_nxt.pc_sel = PC_GTO;
			default:                        legal = 1'b0;  // falls through as nop
		endcase
		if (clr_i) begin
			dec_nxt.pc_sel = PC_CLR;  // clear beats interrupt
		end else if (intr_i) begin
			dec_nxt.pc_sel = PC_INTR;
		end
		dec_nxt.tst     = op_code_i.jmp_fmt.tst;
		dec_nxt.im_addr = op_code_i.jmp_fmt.im_addr;
		dec_nxt.thrd    = thrd_i;  // tag with owner
	end

	always_comb begin
		alu_nxt.valid   = issue;
		alu_nxt.lit     = issue & (op_cls == OP_LIT);
		alu_nxt.add     = issue & (op_cls == OP_ADD);
		alu_nxt.sub     = issue & (op_cls == OP_SUB);
		alu_nxt.im_data = op_code_i.lit_fmt.im_data;  // literal view
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			// stage 1 after reset holds the last thread, clear it too
			dec_o.pc_sel  <= PC_CLR;
			dec_o.tst     <= TST_ALWAYS;
			dec_o.im_addr <= '0;
			dec_o.thrd    <= THRD_W'(THREADS - 1);
			alu_ctrl_o    <= '0;
			op_code_er_o  <= 1'b0;
		end else begin
			dec_o         <= dec_nxt;
			alu_ctrl_o    <= alu_nxt;
			op_code_er_o  <= ~legal & ~evt;  // events mask the opcode
		end
	end

endmodule

`default_nettype wire

// File: src/pc_ring.sv
// eight stage pc ring with jump condition test and next pc select
`timescale 1ns/1ns
`default_nettype none

module pc_ring import ctrl_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  dec_s              dec_i,    // stage 1 decode
	input  logic              nez_i,    // a != 0, stage 1
	input  logic              ltz_i,    // a < 0, stage 1
	input  logic [B_LO_W-1:0] b_lo_i,   // goto target, stage 1
	output logic [ADDR_W-1:0] pc_0_o    // fetch address
);

	logic [ADDR_W-1:0] ring [THREADS];  // one pc per stage
	logic [ADDR_W-1:0] pc_1;
	logic [ADDR_W-1:0] pc_inc;
	logic [ADDR_W-1:0] pc_ofs;           // sign extended offset
	logic [ADDR_W-1:0] vec_thrd;         // thread id in pc width
	logic [ADDR_W-1:0] pc_nxt;
	logic              tst_ok;

	assign pc_1     = ring[1];
	assign pc_inc   = pc_1 + 1'b1;
	assign pc_ofs   = {{(ADDR_W-IM_ADDR_W){dec_i.im_addr[IM_ADDR_W-1]}}, dec_i.im_addr};
	assign vec_thrd = ADDR_W'(dec_i.thrd);

	always_comb begin
		case (dec_i.tst)
			TST_NEZ: tst_ok = nez_i;
			TST_LTZ: tst_ok = ltz_i;
			TST_GEZ: tst_ok = ~ltz_i;
			default: tst_ok = 1'b1;  // always
		endcase
	end

	always_comb begin
		case (dec_i.pc_sel)
			PC_JMP:  pc_nxt = tst_ok ? pc_1 + pc_ofs : pc_inc;
			PC_GTO:  pc_nxt = ADDR_W'(b_lo_i);
			PC_CLR:  pc_nxt = CLR_BASE | vec_thrd;
			PC_INTR: pc_nxt = INTR_BASE | vec_thrd;
			default: pc_nxt = pc_inc;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < THREADS; i++) begin
				ring[i] <= '0;
			end
		end else begin
			ring[0] <= ring[THREADS-1];  // close the loop
			ring[1] <= ring[0];
			ring[2] <= pc_nxt;           // updated pc enters here
			for (int i = 3; i < THREADS; i++) begin
				ring[i] <= ring[i-1];
			end
		end
	end

	assign pc_0_o = ring[0];

endmodule

`default_nettype wire

// File: src/control_ring.sv
// control path top with thread ring, clear and interrupt controllers, decoder and pc ring
`timescale 1ns/1ns
`default_nettype none

module control_ring import ctrl_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic [THREADS-1:0] clr_req_i,     // clear requests
	output logic [THREADS-1:0] clr_ack_o,     // held until serviced
	input  logic [THREADS-1:0] intr_en_i,
	input  logic [THREADS-1:0] intr_req_i,    // interrupt requests
	output logic [THREADS-1:0] intr_ack_o,    // held until serviced
	input  op_word_u           op_code_i,     // same cycle as pc_0_o
	output logic               op_code_er_o,
	output alu_ctrl_s          alu_ctrl_o,
	input  logic               nez_i,
	input  logic               ltz_i,
	input  logic [B_LO_W-1:0]  b_lo_i,
	output logic [THRD_W-1:0]  thrd_0_o,
	output logic [THRD_W-1:0]  thrd_1_o,
	output logic [ADDR_W-1:0]  pc_0_o
);

	logic thrd_clr;   // clear strobe, stage 0
	logic thrd_intr;  // interrupt strobe, stage 0
	dec_s dec;        // stage 1 decode

	thread_ring thread_ring_i (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.thrd_0_o (thrd_0_o),
		.thrd_1_o (thrd_1_o)
	);

	event_ctrl #(
		.RESET_VAL ({THREADS{1'b1}})  // every thread cleared on its first turn
	) clr_event_ctrl (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.thrd_i  (thrd_0_o),
		.en_i    ({THREADS{1'b1}}),  // clears never masked
		.req_i   (clr_req_i),
		.ack_o   (clr_ack_o),
		.event_o (thrd_clr)
	);

	event_ctrl #(
		.RESET_VAL ('0)
	) intr_event_ctrl (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.thrd_i  (thrd_0_o),
		.en_i    (intr_en_i),
		.req_i   (intr_req_i),
		.ack_o   (intr_ack_o),
		.event_o (thrd_intr)
	);

	op_decode op_decode_i (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.thrd_i       (thrd_0_o),
		.clr_i        (thrd_clr),
		.intr_i       (thrd_intr),
		.op_code_i    (op_code_i),
		.dec_o        (dec),
		.alu_ctrl_o   (alu_ctrl_o),
		.op_code_er_o (op_code_er_o)
	);

	pc_ring pc_ring_i (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.dec_i   (dec),
		.nez_i   (nez_i),
		.ltz_i   (ltz_i),
		.b_lo_i  (b_lo_i),
		.pc_0_o  (pc_0_o)
	);

endmodule

`default_nettype wire

// File: verif/control_ring_tb.sv
// testbench with clock, reset, lfsr stimulus, pc reference model, assertion checks and timeout
`timescale 1ns/1ns
`default_nettype none

module control_ring_tb import ctrl_pkg::*; ();

	localparam int RUN_CYCLES = 400;                          // stimulus length
	localparam int TIMEOUT    = RUN_CYCLES + RUN_CYCLES / 2;  // hang guard
	localparam int HIT_N      = 7;                            // stimulus goals

	logic               clk_i;
	logic               rst_n_i;
	logic [THREADS-1:0] clr_req_i;
	logic [THREADS-1:0] clr_ack_o;
	logic [THREADS-1:0] intr_en_i;
	logic [THREADS-1:0] intr_req_i;
	logic [THREADS-1:0] intr_ack_o;
	logic [OP_CODE_W-1:0] op_code;     // program word at pc_0_o
	logic               op_code_er_o;
	alu_ctrl_s          alu_ctrl_o;
	logic               nez_i;
	logic               ltz_i;
	logic [B_LO_W-1:0]  b_lo_i;
	logic [THRD_W-1:0]  thrd_0_o;
	logic [THRD_W-1:0]  thrd_1_o;
	logic [ADDR_W-1:0]  pc_0_o;

	logic [OP_CODE_W-1:0] prog [256];  // indexed by thread and low pc bits
	logic [31:0]        lfsr;
	int                 cycles;
	int                 hits [HIT_N];
	string              hit_name [HIT_N] = '{"jump taken", "jump not taken", "goto",
		"interrupt", "illegal opcode", "clear request", "masked interrupt"};

	// reference model state
	logic [ADDR_W-1:0]  model_pc [THREADS];
	string              model_src [THREADS];  // what produced that pc
	logic [THREADS-1:0] clr_pend;
	logic [THREADS-1:0] intr_pend;
	logic [THREADS-1:0] clr_req_q;
	logic [THREADS-1:0] intr_req_q;
	logic [THRD_W-1:0]  exp_thrd;
	logic [1:0]         s1_evt;           // 0 none, 1 clear, 2 interrupt
	logic [OP_CODE_W-1:0] s1_word;
	logic [ADDR_W-1:0]  s1_pc;
	logic [THRD_W-1:0]  s1_thrd;

	control_ring control_ring_i (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.clr_req_i    (clr_req_i),
		.clr_ack_o    (clr_ack_o),
		.intr_en_i    (intr_en_i),
		.intr_req_i   (intr_req_i),
		.intr_ack_o   (intr_ack_o),
		.op_code_i    (op_code),
		.op_code_er_o (op_code_er_o),
		.alu_ctrl_o   (alu_ctrl_o),
		.nez_i        (nez_i),
		.ltz_i        (ltz_i),
		.b_lo_i       (b_lo_i),
		.thrd_0_o     (thrd_0_o),
		.thrd_1_o     (thrd_1_o),
		.pc_0_o       (pc_0_o)
	);

	assign op_code = prog[{thrd_0_o, pc_0_o[4:0]}];  // same cycle fetch

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;  // 100 ns period
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else
			stop_on_error($sformatf("mismatch %s: expected %0h, actual %0h", name, exp, act));
	endtask

	task automatic fill_program();
		logic [31:0] r;
		logic [31:0] f;
		for (int i = 0; i < 256; i++) begin
			take_bits(3, r);
			take_bits(8, f);
			if (r == 32'd4) begin
				prog[i] = {4'd4, f[7:6], 4'b0, f[5:0]};  // jump, test and offset
			end else if (r < 32'd6) begin
				prog[i] = {r[3:0], 4'b0, f[7:0]};        // nop, lit, add, sub, goto
			end else begin
				prog[i] = {f[3] ? {1'b0, r[2:0]} : {1'b1, f[2:0]}, 12'h000};  // 6 to 15 illegal
			end
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < THREADS; i++) begin
			model_pc[i]  = '0;       // every stage pc starts at zero
			model_src[i] = "reset";
		end
		clr_pend   = '1;              // all threads owe a clear
		intr_pend  = '0;
		clr_req_q  = '0;
		intr_req_q = '0;
		exp_thrd   = '0;
		s1_evt     = 2'd1;            // last thread sits in stage 1 as a clear
		s1_thrd    = THRD_W'(THREADS - 1);
		s1_word    = '0;
		s1_pc      = '0;
	endtask

	// retires the previous fetch whose flags and b_lo are on the inputs now
	task automatic retire_stage1();
		logic [3:0]        cls;
		logic [ADDR_W-1:0] npc;
		logic              take;
		logic              legal;
		string             src;
		cls   = s1_word[15:12];
		legal = (cls <= 4'd5);
		case (s1_word[11:10])
			2'd1:    take = nez_i;
			2'd2:    take = ltz_i;
			2'd3:    take = !ltz_i;
			default: take = 1'b1;
		endcase
		npc = s1_pc + 16'd1;
		src = legal ? "nop or alu" : "illegal opcode";
		if (s1_evt == 2'd1) begin
			npc = CLR_BASE | {13'b0, s1_thrd};
			src = "clear";
		end else if (s1_evt == 2'd2) begin
			npc = INTR_BASE | {13'b0, s1_thrd};
			src = "interrupt";
			hits[3]++;
		end else if (cls == 4'd4) begin
			npc = take ? s1_pc + {{10{s1_word[5]}}, s1_word[5:0]} : npc;
			src = take ? "jump taken" : "jump not taken";
			hits[take ? 0 : 1]++;
		end else if (cls == 4'd5) begin
			npc = b_lo_i;
			src = "goto";
			hits[2]++;
		end else if (!legal) begin
			hits[4]++;
		end
		model_pc[s1_thrd]  = npc;
		model_src[s1_thrd] = src;
		check_value("alu valid", legal && s1_evt == 2'd0, alu_ctrl_o.valid);
		check_value("alu op bits",
			(s1_evt == 2'd0) ? {cls == 4'd1, cls == 4'd2, cls == 4'd3} : 3'b000,
			{alu_ctrl_o.lit, alu_ctrl_o.add, alu_ctrl_o.sub});
		if (alu_ctrl_o.valid) begin
			check_value("alu im_data", s1_word[7:0], alu_ctrl_o.im_data);
		end
		check_value("illegal opcode flag", !legal && s1_evt == 2'd0, op_code_er_o);
	endtask

	task automatic fetch_stage0();
		logic [THRD_W-1:0]  prev;
		logic [THREADS-1:0] clr_rise;
		logic [THREADS-1:0] intr_rise;
		prev      = exp_thrd - 3'd1;
		clr_rise  = clr_req_i & ~clr_req_q;
		intr_rise = intr_req_i & ~intr_req_q;
		check_value("thread at fetch", exp_thrd, thrd_0_o);
		check_value("thread at decode", prev, thrd_1_o);
		check_value({"pc after ", model_src[exp_thrd]}, model_pc[exp_thrd], pc_0_o);
		check_value("clear ack", clr_pend, clr_ack_o);
		check_value("interrupt ack", intr_pend, intr_ack_o);
		s1_evt  = clr_pend[exp_thrd] ? 2'd1 : (intr_pend[exp_thrd] ? 2'd2 : 2'd0);
		s1_word = op_code;
		s1_pc   = pc_0_o;
		s1_thrd = exp_thrd;
		clr_pend[exp_thrd]  = 1'b0;  // both services happen on the turn
		intr_pend[exp_thrd] = 1'b0;
		clr_pend   = clr_pend | clr_rise;
		intr_pend  = intr_pend | (intr_rise & intr_en_i);
		hits[5]   += (clr_rise != '0) ? 1 : 0;
		hits[6]   += ((intr_rise & ~intr_en_i) != '0) ? 1 : 0;
		clr_req_q  = clr_req_i;
		intr_req_q = intr_req_i;
		exp_thrd   = exp_thrd + 3'd1;
	endtask

	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			reset_model();
		end else begin
			retire_stage1();  // writes the pc of the thread before
			fetch_stage0();
		end
	end

	always @(posedge clk_i) begin
		logic [31:0] r;
		take_bits(2, r);
		nez_i <= r[0];
		ltz_i <= r[1];
		take_bits(16, r);
		b_lo_i <= r[15:0];
		take_bits(7, r);
		if (r[3:0] == 4'd0) clr_req_i <= clr_req_i ^ (8'b1 << r[6:4]);  // rare clears
		take_bits(6, r);
		if (r[2:0] == 3'd0) intr_req_i <= intr_req_i ^ (8'b1 << r[5:3]);
		take_bits(7, r);
		if (r[3:0] == 4'd0) intr_en_i <= intr_en_i ^ (8'b1 << r[6:4]);
	end

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			stop_on_error($sformatf("timeout, run still going after %0d cycles", cycles));
		end
	end

	task automatic check_reached();
		for (int i = 0; i < HIT_N; i++) begin
			assert (hits[i] > 0) else
				stop_on_error($sformatf("stimulus never reached %s", hit_name[i]));
		end
	endtask

	initial begin
		rst_n_i    = 1'b0;
		clr_req_i  = '0;
		intr_en_i  = 8'h5a;  // half the threads take interrupts
		intr_req_i = '0;
		nez_i      = 1'b0;
		ltz_i      = 1'b0;
		b_lo_i     = '0;
		cycles     = 0;
		for (int i = 0; i < HIT_N; i++) begin
			hits[i] = 0;
		end
		lfsr = 32'h9eda;
		fill_program();
		repeat (2) @(posedge clk_i);
		rst_n_i <= 1'b1;
		repeat (RUN_CYCLES) @(posedge clk_i);
		@(negedge clk_i);  // after the checks of the last edge
		check_reached();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
src/ctrl_pkg.sv
src/thread_ring.sv
src/event_ctrl.sv
src/op_decode.sv
src/pc_ring.sv
src/control_ring.sv
verif/control_ring_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then judge the result from sim.log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module control_ring_tb -o control_ring_sim > build.log 2>&1 \
	&& ./obj_dir/control_ring_sim > sim.log 2>&1 \
	|| echo "build or simulation ended with an error status"
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
exit 0
